//--- hw/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // Cluster and bus sizes
    localparam int unsigned NB_CORES   = 4;     // Private instruction caches
    localparam int unsigned ID_WIDTH   = 5;     // Bus transaction id
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned ADDR_WIDTH = 32;

    // Register map, only the low address byte is decoded
    localparam logic [7:0] OFF_ENABLE = 8'h00;  // Per-core cache enable
    localparam logic [7:0] OFF_FLUSH  = 8'h04;  // Per-core flush request
    localparam logic [7:0] OFF_MARKER = 8'h08;  // Reserved word

    // Fixed read values
    localparam logic [DATA_WIDTH-1:0] MARKER_RDATA   = 32'hBADD_A555;
    localparam logic [DATA_WIDTH-1:0] UNMAPPED_RDATA = 32'hDEAD_A555;

    // Write command from the register file to the sequencer
    typedef enum logic [2:0]
    {
        CMD_NONE,       // No write this cycle
        CMD_ENABLE,     // Nonzero write to the enable register
        CMD_DISABLE,    // Zero written to the enable register
        CMD_FLUSH,      // Any write to the flush register
        CMD_OTHER       // Write to an offset without side effects
    } ctrl_cmd_e;

endpackage

//--- hw/periph_req_if.sv
`timescale 1ns/1ps

interface periph_req_if
    import icache_ctrl_pkg::*;
();

    logic                  req;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  wen;     // High means read
    logic [DATA_WIDTH-1:0] wdata;
    logic [ID_WIDTH-1:0]   id;
    logic                  gnt;     // Accept when req and gnt are both high

    // Bus side, drives the request fields
    modport source
    (
        output req,
        output addr,
        output wen,
        output wdata,
        output id,
        input  gnt
    );

    // Register file observes the whole channel
    modport regs
    (
        input req,
        input addr,
        input wen,
        input wdata,
        input id,
        input gnt
    );

    modport ctrl
    (
        input  req,
        output gnt
    );

endinterface

//--- hw/ack_collector.sv
`timescale 1ns/1ps

module ack_collector
    import icache_ctrl_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                listen_i,
    input  logic                clear_i,
    input  logic [NB_CORES-1:0] match_i,

    output logic                all_done_o
);

    logic [NB_CORES-1:0] seen_q;    // One sticky bit per core

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            seen_q <= '0;
        end
        else if (clear_i)
        begin
            seen_q <= '0;   // Clear wins over a late match
        end
        else if (listen_i)
        begin
            seen_q <= seen_q | match_i;
        end
    end

    // Done once every core has answered at least once
    assign all_done_o = &seen_q;

endmodule

//--- hw/icache_ctrl_regs.sv
`timescale 1ns/1ps

module icache_ctrl_regs
    import icache_ctrl_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    periph_req_if.regs            bus,

    input  logic                  wr_done_i,
    output ctrl_cmd_e             cmd_o,

    output logic                  r_valid_o,
    output logic [DATA_WIDTH-1:0] r_rdata_o,
    output logic [ID_WIDTH-1:0]   r_id_o,
    output logic                  r_opc_o,

    output logic [NB_CORES-1:0]   bypass_req_o,
    output logic [NB_CORES-1:0]   flush_req_o
);

    logic                  accept;
    logic                  is_read;
    logic                  is_write;
    logic [7:0]            offset;
    logic [DATA_WIDTH-1:0] rd_mux;

    logic [DATA_WIDTH-1:0] enable_q;
    logic [DATA_WIDTH-1:0] flush_q;
    logic                  r_valid_q;
    logic [DATA_WIDTH-1:0] r_rdata_q;
    logic [ID_WIDTH-1:0]   r_id_q;

    assign accept   = bus.req & bus.gnt;
    assign is_read  = accept & bus.wen;
    assign is_write = accept & ~bus.wen;
    assign offset   = bus.addr[7:0];

    // Command decode for the sequencer
    always_comb
    begin
        cmd_o = CMD_NONE;
        if (is_write)
        begin
            case (offset)
                OFF_ENABLE: cmd_o = (bus.wdata == '0) ? CMD_DISABLE : CMD_ENABLE;
                OFF_FLUSH:  cmd_o = CMD_FLUSH;
                default:    cmd_o = CMD_OTHER;  // Still needs a response
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q <= '0;     // All caches bypassed
            flush_q  <= '0;
        end
        else if (is_write)
        begin
            if (offset == OFF_ENABLE)
            begin
                enable_q <= bus.wdata;
            end
            if (offset == OFF_FLUSH)
            begin
                flush_q <= bus.wdata;
            end
        end
    end

    // Cores see the register contents directly
    assign bypass_req_o = ~enable_q[NB_CORES-1:0];
    assign flush_req_o  = flush_q[NB_CORES-1:0];

    always_comb
    begin
        case (offset)
            OFF_ENABLE: rd_mux = enable_q;
            OFF_FLUSH:  rd_mux = flush_q;
            OFF_MARKER: rd_mux = MARKER_RDATA;
            default:    rd_mux = UNMAPPED_RDATA;
        endcase
    end

    // One-shot response, reads next cycle and writes after the sequencer is done
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            r_valid_q <= 1'b0;
        end
        else
        begin
            r_valid_q <= is_read | wr_done_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (is_read)
        begin
            r_rdata_q <= rd_mux;
        end
        else if (wr_done_i)
        begin
            r_rdata_q <= '0;    // Write responses carry no data
        end

        if (accept)
        begin
            r_id_q <= bus.id;
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_rdata_o = r_rdata_q;
    assign r_id_o    = r_id_q;
    assign r_opc_o   = 1'b0;    // No error responses

endmodule

//--- hw/icache_ctrl_fsm.sv
`timescale 1ns/1ps

module icache_ctrl_fsm
    import icache_ctrl_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,

    periph_req_if.ctrl          bus,

    input  ctrl_cmd_e           cmd_i,
    input  logic [NB_CORES-1:0] bypass_ack_i,
    input  logic [NB_CORES-1:0] flush_ack_i,
    input  logic [NB_CORES-1:0] flush_req_i,

    output logic                wr_done_o
);

    enum logic [2:0]
    {
        IDLE,
        WAIT_ENABLE,
        WAIT_DISABLE,
        WAIT_FLUSH,
        RESPOND
    } state_q, state_d;

    logic                bypass_listen;
    logic                bypass_clear;
    logic                bypass_done;
    logic [NB_CORES-1:0] bypass_match;

    logic                flush_listen;
    logic                flush_clear;
    logic                flush_done;
    logic [NB_CORES-1:0] flush_match;

    // Enabling waits for bypass acks to drop, disabling for them to rise
    assign bypass_listen = (state_q == WAIT_ENABLE) || (state_q == WAIT_DISABLE);
    assign bypass_match  = (state_q == WAIT_ENABLE) ? ~bypass_ack_i : bypass_ack_i;

    // Cores without a flush request have nothing to report
    assign flush_listen = (state_q == WAIT_FLUSH);
    assign flush_match  = flush_ack_i | ~flush_req_i;

    ack_collector u_bypass_acks
    (
        .clk_i      ( clk_i         ),
        .rst_ni     ( rst_ni        ),
        .listen_i   ( bypass_listen ),
        .clear_i    ( bypass_clear  ),
        .match_i    ( bypass_match  ),
        .all_done_o ( bypass_done   )
    );

    ack_collector u_flush_acks
    (
        .clk_i      ( clk_i        ),
        .rst_ni     ( rst_ni       ),
        .listen_i   ( flush_listen ),
        .clear_i    ( flush_clear  ),
        .match_i    ( flush_match  ),
        .all_done_o ( flush_done   )
    );

    always_comb
    begin
        state_d      = state_q;
        bypass_clear = 1'b0;
        flush_clear  = 1'b0;

        case (state_q)
            IDLE:
            begin
                if (bus.req)
                begin
                    case (cmd_i)
                        CMD_ENABLE:  state_d = WAIT_ENABLE;
                        CMD_DISABLE: state_d = WAIT_DISABLE;
                        CMD_FLUSH:   state_d = WAIT_FLUSH;
                        CMD_OTHER:   state_d = RESPOND;
                        default:     state_d = IDLE;    // Reads are answered by the regs
                    endcase
                end
            end
            WAIT_ENABLE, WAIT_DISABLE:
            begin
                if (bypass_done)
                begin
                    bypass_clear = 1'b1;
                    state_d      = RESPOND;
                end
            end
            WAIT_FLUSH:
            begin
                if (flush_done)
                begin
                    flush_clear = 1'b1;
                    state_d     = RESPOND;
                end
            end
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    assign bus.gnt   = (state_q == IDLE);       // Stall the bus during a write
    assign wr_done_o = (state_q == RESPOND);

endmodule

//--- hw/icache_ctrl_unit.sv
`timescale 1ns/1ps

module icache_ctrl_unit
    import icache_ctrl_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Peripheral bus request channel
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic                  wen_i,    // High means read
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [ID_WIDTH-1:0]   id_i,
    output logic                  gnt_o,

    // Response channel
    output logic                  r_valid_o,
    output logic [DATA_WIDTH-1:0] r_rdata_o,
    output logic [ID_WIDTH-1:0]   r_id_o,
    output logic                  r_opc_o,

    // Per-core cache control
    output logic [NB_CORES-1:0]   bypass_req_o,
    input  logic [NB_CORES-1:0]   bypass_ack_i,
    output logic [NB_CORES-1:0]   flush_req_o,
    input  logic [NB_CORES-1:0]   flush_ack_i
);

    ctrl_cmd_e           cmd;
    logic                wr_done;
    logic [NB_CORES-1:0] flush_req;

    periph_req_if bus ();

    assign bus.req   = req_i;
    assign bus.addr  = addr_i;
    assign bus.wen   = wen_i;
    assign bus.wdata = wdata_i;
    assign bus.id    = id_i;
    assign gnt_o     = bus.gnt;

    icache_ctrl_regs u_regs
    (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .bus          ( bus.regs     ),
        .wr_done_i    ( wr_done      ),
        .cmd_o        ( cmd          ),
        .r_valid_o    ( r_valid_o    ),
        .r_rdata_o    ( r_rdata_o    ),
        .r_id_o       ( r_id_o       ),
        .r_opc_o      ( r_opc_o      ),
        .bypass_req_o ( bypass_req_o ),
        .flush_req_o  ( flush_req    )
    );

    // Sequencer also needs the flush mask to skip idle cores
    icache_ctrl_fsm u_fsm
    (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .bus          ( bus.ctrl     ),
        .cmd_i        ( cmd          ),
        .bypass_ack_i ( bypass_ack_i ),
        .flush_ack_i  ( flush_ack_i  ),
        .flush_req_i  ( flush_req    ),
        .wr_done_o    ( wr_done      )
    );

    assign flush_req_o = flush_req;

endmodule

//--- dv/core_ack_model.sv
`timescale 1ns/1ps

module core_ack_model
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic bypass_req_i,
    input  logic flush_req_i,
    output logic bypass_ack_o,
    output logic flush_ack_o
);

    logic [2:0] bypass_wait_q;  // Cycles left before the ack follows
    logic [2:0] flush_wait_q;

    always @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            bypass_ack_o  <= bypass_req_i;  // Caches leave reset settled
            flush_ack_o   <= flush_req_i;
            bypass_wait_q <= '0;
            flush_wait_q  <= '0;
        end
        else
        begin
            if (bypass_ack_o == bypass_req_i)
                bypass_wait_q <= 3'($urandom_range(7, 0));     // Delay for the next change
            else if (bypass_wait_q == '0)
                bypass_ack_o <= bypass_req_i;
            else
                bypass_wait_q <= bypass_wait_q - 3'd1;

            if (flush_ack_o == flush_req_i)
                flush_wait_q <= 3'($urandom_range(7, 0));
            else if (flush_wait_q == '0)
                flush_ack_o <= flush_req_i;
            else
                flush_wait_q <= flush_wait_q - 3'd1;
        end
    end

endmodule

//--- dv/tb_icache_ctrl_unit.sv
`timescale 1ns/1ps

module tb_icache_ctrl_unit
    import icache_ctrl_pkg::*;
();

    localparam int unsigned TIMEOUT_CYCLES = 2000;  // About 300 cycles of tests plus margin

    logic                  clk_i, rst_ni, req_i, wen_i, gnt_o, r_valid_o, r_opc_o;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [DATA_WIDTH-1:0] wdata_i, r_rdata_o;
    logic [ID_WIDTH-1:0]   id_i, r_id_o;
    logic [NB_CORES-1:0]   bypass_req_o, flush_req_o;
    wire  [NB_CORES-1:0]   bypass_ack_i, flush_ack_i;
    logic                  write_pending = 1'b0;   // Write accepted and response not yet seen
    int unsigned           cycle_count = 0;
    int unsigned           latency;

    icache_ctrl_unit UUT (.*);

    for (genvar c = 0; c < NB_CORES; c++)
    begin : g_cores
        core_ack_model u_core
        (
            .clk_i        ( clk_i           ),
            .rst_ni       ( rst_ni          ),
            .bypass_req_i ( bypass_req_o[c] ),
            .flush_req_i  ( flush_req_o[c]  ),
            .bypass_ack_o ( bypass_ack_i[c] ),
            .flush_ack_o  ( flush_ack_i[c]  )
        );
    end

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (!rst_ni || r_valid_o)
            write_pending <= 1'b0;
        if (req_i && gnt_o && !wen_i)
            write_pending <= 1'b1;  // A new write wins over an old response
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
            finish_failed();
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     r_valid_o && !(req_i && gnt_o) |=> !r_valid_o)
    else
    begin
        $display("Response valid stayed high a second cycle without a new accept");
        finish_failed();
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     write_pending && !r_valid_o |-> !gnt_o)
    else
    begin
        $display("Grant was high while a register write waited for its response");
        finish_failed();
    end

    task automatic finish_failed();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            finish_failed();
        end
    endtask

    // Returns right after the accepting edge
    task automatic send_request(input logic [ADDR_WIDTH-1:0] a, input logic rd,
                                input logic [DATA_WIDTH-1:0] d, input logic [ID_WIDTH-1:0] t);
        @(negedge clk_i);
        req_i   = 1'b1;
        addr_i  = a;
        wen_i   = rd;
        wdata_i = d;
        id_i    = t;
        while (!gnt_o)
            @(negedge clk_i);
        @(posedge clk_i);
    endtask

    task automatic read_check(input string name, input logic [ADDR_WIDTH-1:0] a,
                              input logic [ID_WIDTH-1:0] t, input logic [DATA_WIDTH-1:0] exp);
        send_request(a, 1'b1, '0, t);
        @(negedge clk_i);
        req_i = 1'b0;
        check_value({name, " valid"}, 1, r_valid_o);  // Exactly one cycle after accept
        check_value(name, exp, r_rdata_o);
        check_value({name, " id"}, t, r_id_o);
        check_value({name, " opc"}, 0, r_opc_o);
    endtask

    task automatic write_check(input string name, input logic [ADDR_WIDTH-1:0] a,
                               input logic [DATA_WIDTH-1:0] d, input logic [ID_WIDTH-1:0] t,
                               output int unsigned lat);
        send_request(a, 1'b0, d, t);
        @(negedge clk_i);
        req_i = 1'b0;
        lat   = 1;
        while (!r_valid_o)
        begin
            @(negedge clk_i);
            lat++;
        end
        check_value({name, " rdata"}, 0, r_rdata_o);
        check_value({name, " id"}, t, r_id_o);
        check_value({name, " opc"}, 0, r_opc_o);
    endtask

    initial
    begin
        void'($urandom(32'hd458));
        clk_i   = 1'b0;
        rst_ni  = 1'b0;
        req_i   = 1'b0;
        addr_i  = '0;
        wen_i   = 1'b1;
        wdata_i = '0;
        id_i    = '0;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;

        @(negedge clk_i);
        check_value("reset gnt", 1, gnt_o);
        check_value("reset bypass_req", 4'hF, bypass_req_o);
        check_value("reset flush_req", 0, flush_req_o);
        read_check("reset enable", OFF_ENABLE, 5'h01, 0);
        read_check("reset flush", OFF_FLUSH, 5'h02, 0);
        read_check("marker", OFF_MARKER, 5'h03, MARKER_RDATA);
        read_check("unmapped read", 32'h20, 5'h04, UNMAPPED_RDATA);

        // Low nibble all ones enables every core
        write_check("enable", OFF_ENABLE, 32'h1234_567F, 5'h05, latency);
        check_value("enable bypass_req", 0, bypass_req_o);
        check_value("enable bypass_ack", 0, bypass_ack_i);
        read_check("enable readback", OFF_ENABLE, 5'h06, 32'h1234_567F);

        write_check("disable", OFF_ENABLE, 0, 5'h07, latency);
        check_value("disable bypass_req", 4'hF, bypass_req_o);
        check_value("disable bypass_ack", 4'hF, bypass_ack_i);

        write_check("flush mask", OFF_FLUSH, 32'h5, 5'h08, latency);
        check_value("flush mask req", 4'h5, flush_req_o);
        check_value("flush mask ack", 4'h5, flush_ack_i & 4'h5);
        read_check("flush readback", OFF_FLUSH, 5'h09, 32'h5);
        write_check("flush zero", OFF_FLUSH, 0, 5'h0A, latency);
        check_value("flush zero latency", 4, latency);  // Listen and done cycles before wr_done
        check_value("flush zero req", 0, flush_req_o);

        write_check("unmapped write", 32'h20, 32'hFFFF_FFFF, 5'h0B, latency);
        check_value("unmapped write latency", 2, latency);
        read_check("unmapped enable", OFF_ENABLE, 5'h0C, 0);
        read_check("unmapped flush", OFF_FLUSH, 5'h0D, 0);

        // A read held behind a busy write is taken with the write's response
        send_request(OFF_ENABLE, 1'b0, 32'h0000_000F, 5'h10);
        @(negedge clk_i);
        wen_i = 1'b1;
        id_i  = 5'h11;
        while (!r_valid_o)
            @(negedge clk_i);
        check_value("held write id", 5'h10, r_id_o);
        check_value("held write rdata", 0, r_rdata_o);
        @(negedge clk_i);
        req_i = 1'b0;
        check_value("held read valid", 1, r_valid_o);
        check_value("held read rdata", 32'h0000_000F, r_rdata_o);
        check_value("held read id", 5'h11, r_id_o);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- icache_ctrl_unit.f
hw/icache_ctrl_pkg.sv
hw/periph_req_if.sv
hw/ack_collector.sv
hw/icache_ctrl_regs.sv
hw/icache_ctrl_fsm.sv
hw/icache_ctrl_unit.sv
dv/core_ack_model.sv
dv/tb_icache_ctrl_unit.sv

//--- Bender.yml
package:
  name: icache_ctrl_unit

sources:
  - files:
      - hw/icache_ctrl_pkg.sv
      - hw/periph_req_if.sv
      - hw/ack_collector.sv
      - hw/icache_ctrl_regs.sv
      - hw/icache_ctrl_fsm.sv
      - hw/icache_ctrl_unit.sv
  - target: simulation
    files:
      - dv/core_ack_model.sv
      - dv/tb_icache_ctrl_unit.sv
